//--- hdl/aluUnit.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module aluUnit (
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  cpu_pkg::aluOp_e    op,
    output logic [`DATA_W-1:0] result,
    output logic               zero
);
    import cpu_pkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);  // Two's complement compare

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = {{(`DATA_W-1){1'b0}}, lessThan};
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    // Branch compare uses SUB, so equal operands give zero
    assign zero = (result == '0);

endmodule

//--- hdl/cpuCore.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuCore (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instrValid,
    input  cpu_pkg::instrWord_u     instr,
    input  logic [`PC_W-1:0]        pc,
    output logic                    redirect,
    output logic [`PC_W-1:0]        pcTarget,
    output logic                    storeValid,
    output logic [`DMEM_ADDR_W-1:0] storeAddr,
    output logic [`DATA_W-1:0]      storeData,
    output cpu_pkg::wbPort_s        wb
);
    import cpu_pkg::*;

    decoded_s              dec;
    execMem_s              exMem;
    logic [`REG_IDX_W-1:0] rfAddrA;
    logic [`REG_IDX_W-1:0] rfAddrB;
    logic [`DATA_W-1:0]    rfDataA;
    logic [`DATA_W-1:0]    rfDataB;

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rfAddrA),
        .rdAddrB (rfAddrB),
        .rdDataA (rfDataA),
        .rdDataB (rfDataB),
        .wb      (wb)
    );

    decodeStage u_decode (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .squash     (redirect),  // Kills the instruction behind a taken branch
        .rfAddrA    (rfAddrA),
        .rfAddrB    (rfAddrB),
        .rfDataA    (rfDataA),
        .rfDataB    (rfDataB),
        .dec        (dec)
    );

    executeStage u_execute (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .wb       (wb),
        .exMem    (exMem),
        .redirect (redirect),
        .pcTarget (pcTarget)
    );

    memWriteback u_memWb (
        .clk   (clk),
        .rst   (rst),
        .exMem (exMem),
        .wb    (wb)
    );

    // Store port taps the M-stage register
    assign storeValid = exMem.memWrite;
    assign storeAddr  = exMem.aluResult[`DMEM_ADDR_W-1:0];
    assign storeData  = exMem.storeData;

endmodule

//--- hdl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath word width
`define DATA_W 18

// Instruction word address width
`define PC_W 9

// Register index width, sixteen registers
`define REG_IDX_W 4

// Number of architectural registers
`define NUM_REGS 16

// Immediate field width in the I form
`define IMM_W 6

// Data memory geometry
`define DMEM_DEPTH 64
`define DMEM_ADDR_W 6

`endif

//--- hdl/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opSlt  = 4'd5,
        opAddi = 4'd6,
        opLw   = 4'd7,
        opSw   = 4'd8,
        opBeq  = 4'd9,
        opJal  = 4'd10
    } opcode_e;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOp_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`REG_IDX_W-1:0]  rs1;
        logic [`REG_IDX_W-1:0]  rs2;
        logic [1:0]             pad;     // Unused in register form
    } rForm_s;

    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_IDX_W-1:0]  rt;      // Dest, or store data / compare source
        logic [`REG_IDX_W-1:0]  rs1;
        logic signed [`IMM_W-1:0] imm;
    } iForm_s;

    // Same 18-bit word seen as either instruction layout
    typedef union packed {
        rForm_s rForm;
        iForm_s iForm;
    } instrWord_u;

    typedef struct packed {
        logic [`DATA_W-1:0]    rs1Data;
        logic [`DATA_W-1:0]    rs2Data;
        logic [`DATA_W-1:0]    imm;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic [`PC_W-1:0]      pc;
        aluOp_e                aluOp;
        logic                  aluSrcImm;
        logic                  regWrite;
        logic                  memWrite;
        logic                  memToReg;
        logic                  branch;
        logic                  jump;
    } decoded_s;

    typedef struct packed {
        logic [`DATA_W-1:0]    aluResult;
        logic [`DATA_W-1:0]    storeData;
        logic [`DATA_W-1:0]    linkData;
        logic [`REG_IDX_W-1:0] rd;
        logic                  regWrite;
        logic                  memWrite;
        logic                  memToReg;
        logic                  link;
    } execMem_s;

    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] regIdx;
        logic [`DATA_W-1:0]    data;
    } wbPort_s;

endpackage

//--- hdl/decodeStage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    input  cpu_pkg::instrWord_u   instr,
    input  logic [`PC_W-1:0]      pc,
    input  logic                  squash,
    output logic [`REG_IDX_W-1:0] rfAddrA,
    output logic [`REG_IDX_W-1:0] rfAddrB,
    input  logic [`DATA_W-1:0]    rfDataA,
    input  logic [`DATA_W-1:0]    rfDataB,
    output cpu_pkg::decoded_s     dec
);
    import cpu_pkg::*;

    decoded_s              nextDec;
    opcode_e               opcode;
    logic                  isRegForm;
    logic [`REG_IDX_W-1:0] rs1Idx;
    logic [`REG_IDX_W-1:0] rs2Idx;
    logic [`REG_IDX_W-1:0] rdIdx;

    assign opcode    = instr.rForm.opcode;
    assign isRegForm = opcode inside {opAdd, opSub, opAnd, opOr, opXor, opSlt};

    // Pick register indexes from whichever layout the opcode implies
    assign rs1Idx = isRegForm ? instr.rForm.rs1 : instr.iForm.rs1;
    assign rs2Idx = isRegForm ? instr.rForm.rs2 : instr.iForm.rt;
    assign rdIdx  = isRegForm ? instr.rForm.rd  : instr.iForm.rt;

    assign rfAddrA = rs1Idx;
    assign rfAddrB = rs2Idx;

    always_comb begin
        nextDec         = '0;  // Unknown opcodes fall out as bubbles
        nextDec.rs1Data = rfDataA;
        nextDec.rs2Data = rfDataB;
        nextDec.imm     = {{(`DATA_W-`IMM_W){instr.iForm.imm[`IMM_W-1]}}, instr.iForm.imm};
        nextDec.rs1     = rs1Idx;
        nextDec.rs2     = rs2Idx;
        nextDec.rd      = rdIdx;
        nextDec.pc      = pc;
        nextDec.aluOp   = aluAdd;

        case (opcode)
            opAdd, opSub, opAnd, opOr, opXor, opSlt: begin
                nextDec.regWrite = 1'b1;
                case (opcode)
                    opSub:   nextDec.aluOp = aluSub;
                    opAnd:   nextDec.aluOp = aluAnd;
                    opOr:    nextDec.aluOp = aluOr;
                    opXor:   nextDec.aluOp = aluXor;
                    opSlt:   nextDec.aluOp = aluSlt;
                    default: nextDec.aluOp = aluAdd;
                endcase
            end
            opAddi: begin
                nextDec.aluSrcImm = 1'b1;
                nextDec.regWrite  = 1'b1;
            end
            opLw: begin
                nextDec.aluSrcImm = 1'b1;  // Address = rs1 + imm
                nextDec.regWrite  = 1'b1;
                nextDec.memToReg  = 1'b1;
            end
            opSw: begin
                nextDec.aluSrcImm = 1'b1;
                nextDec.memWrite  = 1'b1;
            end
            opBeq: begin
                nextDec.aluOp  = aluSub;   // rs1 - rt, zero means equal
                nextDec.branch = 1'b1;
            end
            opJal: begin
                nextDec.aluOp     = aluPassB;
                nextDec.aluSrcImm = 1'b1;
                nextDec.regWrite  = 1'b1;  // rt gets pc+1
                nextDec.jump      = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dec <= '0;
        end else if (instrValid && !squash) begin
            dec <= nextDec;
        end else begin
            dec <= '0;  // Empty slot or wrong-path instruction
        end
    end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module executeStage (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::decoded_s dec,
    input  cpu_pkg::wbPort_s  wb,
    output cpu_pkg::execMem_s exMem,
    output logic              redirect,
    output logic [`PC_W-1:0]  pcTarget
);
    import cpu_pkg::*;

    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluB;
    logic [`DATA_W-1:0] aluResult;
    logic               aluZero;
    logic [`PC_W-1:0]   pcPlusOne;

    // Newest producer wins: M stage first, then the writeback bus
    function automatic logic [`DATA_W-1:0] pickOperand(
        input logic [`REG_IDX_W-1:0] idx,
        input logic [`DATA_W-1:0]    rfVal,
        input execMem_s              mReg,
        input logic [`DATA_W-1:0]    mData,
        input wbPort_s               wbBus
    );
        logic [`DATA_W-1:0] val;
        val = rfVal;
        if (mReg.regWrite && (mReg.rd == idx) && (idx != '0)) begin
            val = mData;
        end else if (wbBus.valid && (wbBus.regIdx == idx) && (idx != '0)) begin
            val = wbBus.data;
        end
        return val;
    endfunction

    assign srcA = pickOperand(dec.rs1, dec.rs1Data, exMem, exMem.aluResult, wb);
    assign srcB = pickOperand(dec.rs2, dec.rs2Data, exMem, exMem.aluResult, wb);
    assign aluB = dec.aluSrcImm ? dec.imm : srcB;

    aluUnit u_alu (
        .a      (srcA),
        .b      (aluB),
        .op     (dec.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign pcTarget  = dec.pc + dec.imm[`PC_W-1:0];  // Wraps within the 9-bit space
    assign pcPlusOne = dec.pc + `PC_W'(1);
    assign redirect  = dec.jump || (dec.branch && aluZero);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exMem <= '0;
        end else begin
            exMem.aluResult <= aluResult;
            exMem.storeData <= srcB;                  // Forwarded rt for SW
            exMem.linkData  <= {{(`DATA_W-`PC_W){1'b0}}, pcPlusOne};
            exMem.rd        <= dec.rd;
            exMem.regWrite  <= dec.regWrite;
            exMem.memWrite  <= dec.memWrite;
            exMem.memToReg  <= dec.memToReg;
            exMem.link      <= dec.jump;
        end
    end

endmodule

//--- hdl/memWriteback.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module memWriteback (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::execMem_s exMem,
    output cpu_pkg::wbPort_s  wb
);

    logic [`DATA_W-1:0]      mem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]      loadData;
    logic [`DATA_W-1:0]      resultData;

    assign addr = exMem.aluResult[`DMEM_ADDR_W-1:0];  // Upper address bits ignored

    // Memory starts out cleared so early loads read zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (exMem.memWrite) begin
            mem[addr] <= exMem.storeData;
        end
    end

    assign loadData = mem[addr];  // Asynchronous read

    always_comb begin
        if (exMem.memToReg) begin
            resultData = loadData;
        end else if (exMem.link) begin
            resultData = exMem.linkData;
        end else begin
            resultData = exMem.aluResult;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb <= '0;
        end else begin
            // Writes aimed at register 0 never reach the bus
            wb.valid  <= exMem.regWrite && (exMem.rd != '0);
            wb.regIdx <= exMem.rd;
            wb.data   <= resultData;
        end
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module regFile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`REG_IDX_W-1:0] rdAddrA,
    input  logic [`REG_IDX_W-1:0] rdAddrB,
    output logic [`DATA_W-1:0]    rdDataA,
    output logic [`DATA_W-1:0]    rdDataB,
    input  cpu_pkg::wbPort_s      wb
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic               wrEn;

    assign wrEn = wb.valid && (wb.regIdx != '0);  // Register 0 never written

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.regIdx] <= wb.data;
        end
    end

    // Same-cycle write wins so decode sees the value three instructions back
    assign rdDataA = (wrEn && (wb.regIdx == rdAddrA)) ? wb.data : regs[rdAddrA];
    assign rdDataB = (wrEn && (wb.regIdx == rdAddrB)) ? wb.data : regs[rdAddrB];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module cpuCore_tb -f sim.f -o cpuCore_sim
./obj_dir/cpuCore_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

//--- sim.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWriteback.sv
hdl/cpuCore.sv
tb/cpuChecker.sv
tb/cpuCore_tb.sv

//--- tb/cpuChecker.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuChecker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issueValid,
    input  logic [7:0]              issueRow,
    input  logic                    expRedirect,
    input  logic [`PC_W-1:0]        expTarget,
    input  logic                    expStoreValid,
    input  logic [`DMEM_ADDR_W-1:0] expStoreAddr,
    input  logic [`DATA_W-1:0]      expStoreData,
    input  cpu_pkg::wbPort_s        expWb,
    input  logic                    redirect,
    input  logic [`PC_W-1:0]        pcTarget,
    input  logic                    storeValid,
    input  logic [`DMEM_ADDR_W-1:0] storeAddr,
    input  logic [`DATA_W-1:0]      storeData,
    input  cpu_pkg::wbPort_s        wb,
    output int                      rowsPassed,
    output int                      rowsFailed,
    output int                      strayErrors
);
    import cpu_pkg::*;

    typedef struct packed {
        logic                    valid;
        logic                    bad;
        logic [7:0]              row;
        logic                    redirect;
        logic [`PC_W-1:0]        target;
        logic                    storeValid;
        logic [`DMEM_ADDR_W-1:0] storeAddr;
        logic [`DATA_W-1:0]      storeData;
        wbPort_s                 wb;
    } expect_s;

    expect_s atEx;   // Sampled at issue, checked one edge later
    expect_s atMem;
    expect_s atWb;

    task automatic mismatch(input logic inRow, input logic [7:0] row, input string msg);
        if (inRow) begin
            $display("CHECK FAILED at %0t: row %0d %s", $time, row, msg);
        end else begin
            $display("CHECK FAILED at %0t: empty slot %s", $time, msg);
            strayErrors = strayErrors + 1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            atEx        = '0;
            atMem       = '0;
            atWb        = '0;
            rowsPassed  = 0;
            rowsFailed  = 0;
            strayErrors = 0;
        end else begin
            if (redirect !== atEx.redirect) begin
                mismatch(atEx.valid, atEx.row,
                         $sformatf("redirect %b, expected %b", redirect, atEx.redirect));
                atEx.bad = 1'b1;
            end else if (atEx.redirect && (pcTarget !== atEx.target)) begin
                mismatch(atEx.valid, atEx.row,
                         $sformatf("target %0d, expected %0d", pcTarget, atEx.target));
                atEx.bad = 1'b1;
            end

            if (storeValid !== atMem.storeValid) begin
                mismatch(atMem.valid, atMem.row,
                         $sformatf("store valid %b, expected %b", storeValid, atMem.storeValid));
                atMem.bad = 1'b1;
            end else if (atMem.storeValid && ((storeAddr !== atMem.storeAddr) ||
                                              (storeData !== atMem.storeData))) begin
                mismatch(atMem.valid, atMem.row,
                         $sformatf("store [%0d] = %h, expected [%0d] = %h", storeAddr,
                                   storeData, atMem.storeAddr, atMem.storeData));
                atMem.bad = 1'b1;
            end

            if (wb.valid !== atWb.wb.valid) begin
                mismatch(atWb.valid, atWb.row,
                         $sformatf("writeback valid %b, expected %b", wb.valid, atWb.wb.valid));
                atWb.bad = 1'b1;
            end else if (atWb.wb.valid && ((wb.regIdx !== atWb.wb.regIdx) ||
                                           (wb.data !== atWb.wb.data))) begin
                mismatch(atWb.valid, atWb.row,
                         $sformatf("writeback r%0d = %h, expected r%0d = %h", wb.regIdx,
                                   wb.data, atWb.wb.regIdx, atWb.wb.data));
                atWb.bad = 1'b1;
            end

            // Writeback is the last check, so the row is finished here
            if (atWb.valid) begin
                if (atWb.bad) begin
                    rowsFailed = rowsFailed + 1;
                    $display("row %0d: FAIL", atWb.row);
                end else begin
                    rowsPassed = rowsPassed + 1;
                    $display("row %0d: pass", atWb.row);
                end
            end

            atWb             = atMem;
            atMem            = atEx;
            atEx             = '0;
            atEx.valid       = issueValid;
            atEx.row         = issueRow;
            atEx.redirect    = issueValid && expRedirect;  // Empty slots expect silence
            atEx.target      = expTarget;
            atEx.storeValid  = issueValid && expStoreValid;
            atEx.storeAddr   = expStoreAddr;
            atEx.storeData   = expStoreData;
            atEx.wb          = expWb;
            atEx.wb.valid    = issueValid && expWb.valid;
        end
    end

endmodule

//--- tb/cpuCore_tb.sv
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuCore_tb;
    import cpu_pkg::*;

    localparam int NONE = -1;

    typedef struct packed {
        instrWord_u              instr;
        logic [`PC_W-1:0]        pc;
        logic                    squashed;
        logic                    redirect;
        logic [`PC_W-1:0]        target;
        logic                    storeValid;
        logic [`DMEM_ADDR_W-1:0] storeAddr;
        logic [`DATA_W-1:0]      storeData;
        wbPort_s                 wb;
    } row_s;

    logic                    clk;
    logic                    rst;
    logic                    instrValid;
    instrWord_u              instr;
    logic [`PC_W-1:0]        pc;
    logic                    redirect;
    logic [`PC_W-1:0]        pcTarget;
    logic                    storeValid;
    logic [`DMEM_ADDR_W-1:0] storeAddr;
    logic [`DATA_W-1:0]      storeData;
    wbPort_s                 wb;
    logic                    issueValid;
    logic [7:0]              issueRow;
    row_s                    issueExp;
    int                      rowsPassed;
    int                      rowsFailed;
    int                      strayErrors;
    int                      seed;
    int                      liveRows;    // Rows that reach writeback and get a result line
    logic                    tableReady;
    row_s                    rows[$];

    cpuCore u_dut (
        .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc),
        .redirect(redirect), .pcTarget(pcTarget), .storeValid(storeValid),
        .storeAddr(storeAddr), .storeData(storeData), .wb(wb)
    );

    cpuChecker u_chk (
        .clk(clk), .rst(rst), .issueValid(issueValid), .issueRow(issueRow),
        .expRedirect(issueExp.redirect), .expTarget(issueExp.target),
        .expStoreValid(issueExp.storeValid), .expStoreAddr(issueExp.storeAddr),
        .expStoreData(issueExp.storeData), .expWb(issueExp.wb),
        .redirect(redirect), .pcTarget(pcTarget), .storeValid(storeValid),
        .storeAddr(storeAddr), .storeData(storeData), .wb(wb),
        .rowsPassed(rowsPassed), .rowsFailed(rowsFailed), .strayErrors(strayErrors)
    );

    function automatic instrWord_u rInstr(input opcode_e op, input int rd, input int rs1,
                                          input int rs2);
        instrWord_u w;
        w = '0;
        w.rForm.opcode = op;
        w.rForm.rd     = rd[`REG_IDX_W-1:0];
        w.rForm.rs1    = rs1[`REG_IDX_W-1:0];
        w.rForm.rs2    = rs2[`REG_IDX_W-1:0];
        return w;
    endfunction

    function automatic instrWord_u iInstr(input opcode_e op, input int rt, input int rs1,
                                          input int imm);
        instrWord_u w;
        w.iForm.opcode = op;
        w.iForm.rt     = rt[`REG_IDX_W-1:0];
        w.iForm.rs1    = rs1[`REG_IDX_W-1:0];
        w.iForm.imm    = imm[`IMM_W-1:0];
        return w;
    endfunction

    // NONE in target, store address or register means nothing of that kind is expected
    task automatic addRow(input instrWord_u ins, input int pcVal, input int target,
                          input int stAddr, input int stData, input int wbReg, input int wbData);
        row_s r;
        r = '0;
        r.instr      = ins;
        r.pc         = pcVal[`PC_W-1:0];
        r.redirect   = (target != NONE);
        r.target     = target[`PC_W-1:0];
        r.storeValid = (stAddr != NONE);
        r.storeAddr  = stAddr[`DMEM_ADDR_W-1:0];
        r.storeData  = stData[`DATA_W-1:0];
        r.wb.valid   = (wbReg != NONE);
        r.wb.regIdx  = wbReg[`REG_IDX_W-1:0];
        r.wb.data    = wbData[`DATA_W-1:0];
        rows.push_back(r);
        liveRows = liveRows + 1;
    endtask

    task automatic addSquashed(input instrWord_u ins, input int pcVal);
        row_s r;
        r = '0;
        r.instr    = ins;
        r.pc       = pcVal[`PC_W-1:0];
        r.squashed = 1'b1;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        addRow(rInstr(opAdd, 1, 2, 3), 0, NONE, NONE, 0, 1, 0);     // Fresh registers read zero
        addRow(rInstr(opOr, 4, 5, 15), 1, NONE, NONE, 0, 4, 0);
        addRow(iInstr(opAddi, 1, 0, 5), 2, NONE, NONE, 0, 1, 5);
        addRow(iInstr(opAddi, 2, 0, -3), 3, NONE, NONE, 0, 2, -3);
        addRow(rInstr(opAdd, 3, 1, 2), 4, NONE, NONE, 0, 3, 2);
        addRow(rInstr(opSub, 4, 1, 3), 5, NONE, NONE, 0, 4, 3);
        addRow(rInstr(opAnd, 5, 2, 1), 6, NONE, NONE, 0, 5, 5);
        addRow(rInstr(opXor, 6, 2, 4), 7, NONE, NONE, 0, 6, -2);
        addRow(rInstr(opSlt, 7, 2, 1), 8, NONE, NONE, 0, 7, 1);     // -3 < 5 signed
        addRow(rInstr(opSlt, 8, 1, 2), 9, NONE, NONE, 0, 8, 0);
        addRow(rInstr(opAdd, 0, 1, 1), 10, NONE, NONE, 0, NONE, 0); // r0 write dropped
        addRow(rInstr(opAdd, 9, 0, 1), 11, NONE, NONE, 0, 9, 5);
        addRow(iInstr(opAddi, 10, 0, 12), 12, NONE, NONE, 0, 10, 12);
        addRow(iInstr(opSw, 6, 10, 3), 13, NONE, 15, -2, NONE, 0);
        addRow(iInstr(opSw, 5, 10, -2), 14, NONE, 10, 5, NONE, 0);
        addRow(iInstr(opLw, 11, 10, 3), 15, NONE, NONE, 0, 11, -2);
        addRow(iInstr(opAddi, 12, 0, 1), 16, NONE, NONE, 0, 12, 1); // Gap before load user
        addRow(rInstr(opAdd, 13, 11, 12), 17, NONE, NONE, 0, 13, -1);
        addRow(iInstr(opLw, 14, 10, -2), 18, NONE, NONE, 0, 14, 5);
        addRow(iInstr(opAddi, 15, 0, 7), 19, NONE, NONE, 0, 15, 7);
        addRow(iInstr(opBeq, 14, 5, 4), 20, 24, NONE, 0, NONE, 0);  // Taken
        addSquashed(iInstr(opAddi, 1, 0, 9), 21);
        addRow(iInstr(opBeq, 1, 2, 5), 24, NONE, NONE, 0, NONE, 0); // Not taken
        addRow(iInstr(opAddi, 3, 1, 1), 25, NONE, NONE, 0, 3, 6);
        addRow(iInstr(opJal, 2, 0, -6), 26, 20, NONE, 0, 2, 27);
        addSquashed(iInstr(opAddi, 4, 0, 1), 27);
        addRow(rInstr(opAdd, 5, 2, 0), 20, NONE, NONE, 0, 5, 27);
        addRow(iInstr(opBeq, 5, 2, -1), 21, 20, NONE, 0, NONE, 0);
        addSquashed(iInstr(opSw, 2, 0, 0), 22);                      // No store may leak
        addRow(rInstr(opAdd, 6, 4, 0), 20, NONE, NONE, 0, 6, 3);
        addRow(iInstr(opSw, 6, 9, 0), 21, NONE, 5, 3, NONE, 0);
        addRow(iInstr(opLw, 7, 0, 5), 22, NONE, NONE, 0, 7, 3);
    endtask

    task automatic driveIdle();
        instrValid <= 1'b0;
        issueValid <= 1'b0;
    endtask

    task automatic driveRow(input int i);
        instrValid <= 1'b1;
        instr      <= rows[i].instr;
        pc         <= rows[i].pc;
        issueValid <= !rows[i].squashed;  // Squashed rows expect nothing
        issueRow   <= i[7:0];
        issueExp   <= rows[i];
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        wait (tableReady);
        repeat (rows.size() * 4 + 40) @(posedge clk);
        $display("Timeout: the pipeline did not retire every row in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        int gap;
        rst        = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        issueValid = 1'b0;
        issueRow   = '0;
        issueExp   = '0;
        seed       = 32'h1b8b_de28;
        liveRows   = 0;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);  // Idle slots right after reset must stay quiet
        for (int i = 0; i < rows.size(); i++) begin
            if (!rows[i].squashed) begin
                gap = $unsigned($random(seed)) % 3;
                repeat (gap) begin
                    @(posedge clk);
                    driveIdle();
                end
            end
            @(posedge clk);
            driveRow(i);
        end
        @(posedge clk);
        driveIdle();
        wait (rowsPassed + rowsFailed == liveRows);
        repeat (3) @(posedge clk);
        $display("Rows passed: %0d, rows failed: %0d, errors in empty slots: %0d",
                 rowsPassed, rowsFailed, strayErrors);
        if ((rowsFailed == 0) && (strayErrors == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
